//--- src/msx_io_consts.svh
`ifndef MSX_IO_CONSTS_SVH
`define MSX_IO_CONSTS_SVH

// Number of decoded device windows
// Index 0 is the mapper, 1 the PPI, 2 the reset status register
`define MSX_IO_DEVICE_COUNT 3

// Implemented mapper segment bits
// Three bits give 8 segments of 16 KB, unused read bits return 1
`define MSX_MAPPER_SEG_BITS 3

// Rows in the keyboard matrix
`define MSX_KB_ROWS 11

`endif

//--- src/msx_bus_pkg.sv
package msx_bus_pkg;

    // I/O port address as seen on the CPU bus
    typedef logic [7:0] io_port_t;

    // One data byte on the CPU bus
    typedef logic [7:0] io_byte_t;

    // A single I/O access from the CPU
    typedef struct packed {
        io_port_t port;
        logic     write;
        io_byte_t wdata;
    } io_req_t;

    // Handshake progress for the req/ack pair
    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } hs_state_t;

endpackage

//--- src/msx_dev_pkg.sv
`include "msx_io_consts.svh"

package msx_dev_pkg;

    // Device window, a port matches when enabled and equal to base under mask
    typedef struct packed {
        logic                 enable;
        msx_bus_pkg::io_port_t base;
        msx_bus_pkg::io_port_t mask;
    } io_window_t;

    // Per-access command from the decoder to the devices
    typedef struct packed {
        logic                 mapper;
        logic                 ppi;
        logic                 reset_status;
        logic                 write;
        logic [1:0]           offset;
        msx_bus_pkg::io_byte_t wdata;
    } dev_sel_t;

    // Memory mapper segment number
    typedef logic [`MSX_MAPPER_SEG_BITS-1:0] mapper_seg_t;

    // Primary slot register, two bits per page
    typedef logic [7:0] slot_cfg_t;

endpackage

//--- src/io_port_decode.sv
`include "msx_io_consts.svh"

module io_port_decode (
    input  logic                   clk,
    input  logic                   reset,
    input  msx_bus_pkg::io_req_t   io_req_in,
    input  logic                   req,
    input  msx_dev_pkg::io_window_t windows [`MSX_IO_DEVICE_COUNT],
    input  logic                   done,
    output msx_dev_pkg::dev_sel_t  cmd,
    output logic                   cmd_valid
);

    msx_bus_pkg::hs_state_t          state;
    logic [`MSX_IO_DEVICE_COUNT-1:0] match;
    logic [`MSX_IO_DEVICE_COUNT-1:0] winner;
    msx_dev_pkg::dev_sel_t           next_cmd;
    logic                            start;

    // Compare the port against every window
    always_comb begin
        for (int i = 0; i < `MSX_IO_DEVICE_COUNT; i++) begin
            match[i] = windows[i].enable &&
                (((io_req_in.port ^ windows[i].base) & windows[i].mask) == '0);
        end
    end

    // Keep only the lowest matching index
    assign winner = match & ~(match - 1'b1);

    always_comb begin
        next_cmd.mapper       = winner[0];
        next_cmd.ppi          = winner[1];
        next_cmd.reset_status = winner[2];
        next_cmd.write        = io_req_in.write;
        next_cmd.offset       = io_req_in.port[1:0];
        next_cmd.wdata        = io_req_in.wdata;
    end

    assign start = (state == msx_bus_pkg::IDLE) && req;

    // req is ignored until the result stage reports the access as finished
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= msx_bus_pkg::IDLE;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= start;
            case (state)
                msx_bus_pkg::IDLE: if (req) state <= msx_bus_pkg::BUSY;
                msx_bus_pkg::BUSY: if (done) state <= msx_bus_pkg::IDLE;
                default:           state <= msx_bus_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            cmd <= next_cmd;
        end
    end

endmodule

//--- src/dev_mapper_regs.sv
`include "msx_io_consts.svh"

module dev_mapper_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  msx_dev_pkg::dev_sel_t   cmd,
    input  logic                    cmd_valid,
    output msx_bus_pkg::io_byte_t   rd,
    output msx_dev_pkg::mapper_seg_t segments [4]
);

    msx_dev_pkg::mapper_seg_t seg_reg [4];
    logic                     sel_write;
    logic                     sel_read;

    assign sel_write = cmd_valid && cmd.mapper && cmd.write;
    assign sel_read  = cmd_valid && cmd.mapper && !cmd.write;

    // Pages start out mapped to segments 3,2,1,0
    always_ff @(posedge clk) begin
        if (reset) begin
            seg_reg[0] <= msx_dev_pkg::mapper_seg_t'(3);
            seg_reg[1] <= msx_dev_pkg::mapper_seg_t'(2);
            seg_reg[2] <= msx_dev_pkg::mapper_seg_t'(1);
            seg_reg[3] <= msx_dev_pkg::mapper_seg_t'(0);
        end else if (sel_write) begin
            seg_reg[cmd.offset] <= cmd.wdata[`MSX_MAPPER_SEG_BITS-1:0];
        end
    end

    // Upper bits read as 1, as on a small internal mapper
    always_comb begin
        rd = 8'hFF;
        if (sel_read) begin
            rd[`MSX_MAPPER_SEG_BITS-1:0] = seg_reg[cmd.offset];
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            segments[i] = seg_reg[i];
        end
    end

endmodule

//--- src/dev_ppi.sv
`include "msx_io_consts.svh"

module dev_ppi (
    input  logic                  clk,
    input  logic                  reset,
    input  msx_dev_pkg::dev_sel_t cmd,
    input  logic                  cmd_valid,
    input  msx_bus_pkg::io_byte_t kb_rows [`MSX_KB_ROWS],
    output msx_bus_pkg::io_byte_t rd,
    output msx_dev_pkg::slot_cfg_t slot_config,
    output logic                  keybeep
);

    msx_dev_pkg::slot_cfg_t slot_reg;
    msx_bus_pkg::io_byte_t  port_c;
    msx_bus_pkg::io_byte_t  row_data;
    logic [3:0]             row_sel;
    logic                   sel_write;
    logic                   sel_read;

    assign sel_write = cmd_valid && cmd.ppi && cmd.write;
    assign sel_read  = cmd_valid && cmd.ppi && !cmd.write;

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_reg <= '0;
            port_c   <= '0;
        end else if (sel_write) begin
            case (cmd.offset)
                2'd0: slot_reg <= cmd.wdata;
                2'd2: port_c   <= cmd.wdata;
                2'd3: begin
                    // Bit set/reset of port C, mode writes are ignored
                    if (!cmd.wdata[7]) begin
                        port_c[cmd.wdata[3:1]] <= cmd.wdata[0];
                    end
                end
                default: ;
            endcase
        end
    end

    // Keyboard row select lives in the low nibble of port C
    assign row_sel = port_c[3:0];

    always_comb begin
        row_data = 8'hFF;
        if (row_sel < 4'(`MSX_KB_ROWS)) begin
            row_data = kb_rows[row_sel];
        end
    end

    always_comb begin
        rd = 8'hFF;
        if (sel_read) begin
            case (cmd.offset)
                2'd0:    rd = slot_reg;
                2'd1:    rd = row_data;
                2'd2:    rd = port_c;
                default: rd = 8'hFF;
            endcase
        end
    end

    assign slot_config = slot_reg;
    assign keybeep     = port_c[7];

endmodule

//--- src/dev_reset_status.sv
module dev_reset_status (
    input  logic                  clk,
    input  logic                  reset,
    input  msx_dev_pkg::dev_sel_t cmd,
    input  logic                  cmd_valid,
    output msx_bus_pkg::io_byte_t rd,
    output logic                  reset_lock
);

    msx_bus_pkg::io_byte_t status;

    always_ff @(posedge clk) begin
        if (reset) begin
            status <= '0;
        end else if (cmd_valid && cmd.reset_status && cmd.write) begin
            status <= cmd.wdata;
        end
    end

    // Bit 7 reads inverted, boot code uses it to spot a warm start
    always_comb begin
        rd = 8'hFF;
        if (cmd_valid && cmd.reset_status && !cmd.write) begin
            rd = status ^ 8'h80;
        end
    end

    assign reset_lock = status[0];

endmodule

//--- src/io_result_merge.sv
module io_result_merge (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    input  logic                  cmd_valid,
    input  msx_bus_pkg::io_byte_t rd_mapper,
    input  msx_bus_pkg::io_byte_t rd_ppi,
    input  msx_bus_pkg::io_byte_t rd_reset,
    output msx_bus_pkg::io_byte_t rdata,
    output logic                  ack,
    output logic                  done
);

    msx_bus_pkg::hs_state_t state;
    msx_bus_pkg::io_byte_t  rd_all;

    // Idle devices drive all ones, so an unmatched port reads FF
    assign rd_all = rd_mapper & rd_ppi & rd_reset;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= msx_bus_pkg::IDLE;
            rdata <= 8'hFF;
        end else begin
            case (state)
                msx_bus_pkg::IDLE: begin
                    if (cmd_valid) begin
                        rdata <= rd_all;
                        state <= msx_bus_pkg::BUSY;
                    end
                end
                // Hold ack until the CPU drops req
                msx_bus_pkg::BUSY: if (!req) state <= msx_bus_pkg::DONE;
                msx_bus_pkg::DONE: state <= msx_bus_pkg::IDLE;
                default:           state <= msx_bus_pkg::IDLE;
            endcase
        end
    end

    assign ack  = (state == msx_bus_pkg::BUSY);
    assign done = (state == msx_bus_pkg::DONE);

endmodule

//--- src/msx_io_devices.sv
`include "msx_io_consts.svh"

module msx_io_devices (
    input  logic                     clk,
    input  logic                     reset,
    input  msx_bus_pkg::io_req_t     io_req_in,
    input  logic                     req,
    input  msx_dev_pkg::io_window_t  windows [`MSX_IO_DEVICE_COUNT],
    input  msx_bus_pkg::io_byte_t    kb_rows [`MSX_KB_ROWS],
    output logic                     ack,
    output msx_bus_pkg::io_byte_t    rdata,
    output msx_dev_pkg::mapper_seg_t segments [4],
    output msx_dev_pkg::slot_cfg_t   slot_config,
    output logic                     keybeep,
    output logic                     reset_lock
);

    msx_dev_pkg::dev_sel_t cmd;
    logic                  cmd_valid;
    logic                  done;
    msx_bus_pkg::io_byte_t rd_mapper;
    msx_bus_pkg::io_byte_t rd_ppi;
    msx_bus_pkg::io_byte_t rd_reset;

    io_port_decode i_io_port_decode (
        .clk       (clk),
        .reset     (reset),
        .io_req_in (io_req_in),
        .req       (req),
        .windows   (windows),
        .done      (done),
        .cmd       (cmd),
        .cmd_valid (cmd_valid)
    );

    dev_mapper_regs i_dev_mapper_regs (
        .clk       (clk),
        .reset     (reset),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .rd        (rd_mapper),
        .segments  (segments)
    );

    dev_ppi i_dev_ppi (
        .clk         (clk),
        .reset       (reset),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .kb_rows     (kb_rows),
        .rd          (rd_ppi),
        .slot_config (slot_config),
        .keybeep     (keybeep)
    );

    dev_reset_status i_dev_reset_status (
        .clk        (clk),
        .reset      (reset),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .rd         (rd_reset),
        .reset_lock (reset_lock)
    );

    // Combines device read data and closes the handshake
    io_result_merge i_io_result_merge (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .cmd_valid (cmd_valid),
        .rd_mapper (rd_mapper),
        .rd_ppi    (rd_ppi),
        .rd_reset  (rd_reset),
        .rdata     (rdata),
        .ack       (ack),
        .done      (done)
    );

endmodule

//--- verification/io_checker.sv
`include "msx_io_consts.svh"

module io_checker (
    input  logic                     clk,
    input  logic                     reset,
    input  msx_bus_pkg::io_req_t     io_req_in,
    input  logic                     req,
    input  msx_dev_pkg::io_window_t  windows [`MSX_IO_DEVICE_COUNT],
    input  msx_bus_pkg::io_byte_t    kb_rows [`MSX_KB_ROWS],
    input  logic                     ack,
    input  msx_bus_pkg::io_byte_t    rdata,
    input  msx_dev_pkg::mapper_seg_t segments [4],
    input  msx_dev_pkg::slot_cfg_t   slot_config,
    input  logic                     keybeep,
    input  logic                     reset_lock,
    output int                       error_count,
    output int                       access_count
);
    timeunit 1ns;
    timeprecision 1ps;

    msx_dev_pkg::mapper_seg_t m_seg [4];
    msx_dev_pkg::slot_cfg_t   m_slot;
    msx_bus_pkg::io_byte_t    m_portc;
    msx_bus_pkg::io_byte_t    m_status;
    logic                     ack_prev = 1'b0;
    logic                     req_prev = 1'b0;
    int                       errors = 0;
    int                       accesses = 0;

    assign error_count  = errors;
    assign access_count = accesses;

    task automatic report_value(string what, logic [7:0] got, logic [7:0] exp);
        $display("FAILED %0t: %s is %02h, expected %02h", $time, what, got, exp);
        errors++;
    endtask

    task automatic report_problem(string what);
        $display("ERROR %0t: %s", $time, what);
        errors++;
    endtask

    // Lowest window index wins
    // Returns -1 when nothing matches
    function automatic int match_window(msx_bus_pkg::io_port_t port);
        for (int i = 0; i < `MSX_IO_DEVICE_COUNT; i++) begin
            if (windows[i].enable &&
                ((port & windows[i].mask) == (windows[i].base & windows[i].mask))) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic msx_bus_pkg::io_byte_t expected_read(msx_bus_pkg::io_port_t port);
        msx_bus_pkg::io_byte_t value;
        logic [3:0]            row;
        value = 8'hFF;
        row   = m_portc[3:0];
        case (match_window(port))
            0: value = {{(8 - `MSX_MAPPER_SEG_BITS){1'b1}}, m_seg[port[1:0]]};
            1: begin
                if (port[1:0] == 2'd0) begin
                    value = m_slot;
                end else if (port[1:0] == 2'd1 && int'(row) < `MSX_KB_ROWS) begin
                    value = kb_rows[row];
                end else if (port[1:0] == 2'd2) begin
                    value = m_portc;
                end
            end
            2: value = {~m_status[7], m_status[6:0]};
            default: value = 8'hFF;
        endcase
        return value;
    endfunction

    task automatic apply_write(msx_bus_pkg::io_port_t port, msx_bus_pkg::io_byte_t data);
        case (match_window(port))
            0: m_seg[port[1:0]] = data[`MSX_MAPPER_SEG_BITS-1:0];
            1: begin
                if (port[1:0] == 2'd0) begin
                    m_slot = data;
                end else if (port[1:0] == 2'd2) begin
                    m_portc = data;
                end else if (port[1:0] == 2'd3 && !data[7]) begin
                    // Bit set/reset on port C
                    m_portc[data[3:1]] = data[0];
                end
            end
            2: m_status = data;
            default: ;
        endcase
    endtask

    // Read data reflects the registers from before the write of the same access
    task automatic check_access();
        msx_bus_pkg::io_byte_t exp;
        exp = io_req_in.write ? 8'hFF : expected_read(io_req_in.port);
        if (rdata !== exp) begin
            report_value($sformatf("rdata of port %02h", io_req_in.port), rdata, exp);
        end
        if (io_req_in.write) begin
            apply_write(io_req_in.port, io_req_in.wdata);
        end
        accesses++;
    endtask

    task automatic compare_outputs();
        for (int i = 0; i < 4; i++) begin
            if (segments[i] !== m_seg[i]) begin
                report_value($sformatf("segments[%0d]", i), 8'(segments[i]), 8'(m_seg[i]));
            end
        end
        if (slot_config !== m_slot) report_value("slot_config", slot_config, m_slot);
        if (keybeep !== m_portc[7]) report_value("keybeep", 8'(keybeep), 8'(m_portc[7]));
        if (reset_lock !== m_status[0]) begin
            report_value("reset_lock", 8'(reset_lock), 8'(m_status[0]));
        end
    endtask

    // Bus is watched on the falling edge of the clock
    always @(negedge clk) begin
        if (reset) begin
            m_seg[0] = msx_dev_pkg::mapper_seg_t'(3);
            m_seg[1] = msx_dev_pkg::mapper_seg_t'(2);
            m_seg[2] = msx_dev_pkg::mapper_seg_t'(1);
            m_seg[3] = msx_dev_pkg::mapper_seg_t'(0);
            m_slot   = '0;
            m_portc  = '0;
            m_status = '0;
            ack_prev = 1'b0;
            req_prev = 1'b0;
        end else begin
            if (ack && !ack_prev) begin
                // The CPU may drop req as soon as it sees ack, so look at the sample before
                if (!req_prev) report_problem("ack rose while req was low");
                check_access();
            end
            if (ack && ack_prev && !req && !req_prev) begin
                report_problem("ack stayed high after req dropped");
            end
            if (!ack && ack_prev && req_prev) report_problem("ack fell while req was still high");
            compare_outputs();
            ack_prev = ack;
            req_prev = req;
        end
    end

endmodule

//--- verification/tb_msx_io.sv
`include "msx_io_consts.svh"

module tb_msx_io;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 16;
    localparam int          NUM_ACCESSES = 400;
    localparam int          ACK_TIMEOUT  = 50;
    localparam logic [31:0] SEED         = 32'h94ec_eb94;

    logic                     clk = 1'b0;
    logic                     reset;
    msx_bus_pkg::io_req_t     io_req_in;
    logic                     req;
    msx_dev_pkg::io_window_t  windows [`MSX_IO_DEVICE_COUNT];
    msx_bus_pkg::io_byte_t    kb_rows [`MSX_KB_ROWS];
    logic                     ack;
    msx_bus_pkg::io_byte_t    rdata;
    msx_dev_pkg::mapper_seg_t segments [4];
    msx_dev_pkg::slot_cfg_t   slot_config;
    logic                     keybeep;
    logic                     reset_lock;
    int                       error_count;
    int                       access_count;
    int                       timeouts = 0;
    int                       issued = 0;
    logic                     aborted = 1'b0;
    logic [31:0]              lcg_state = SEED;

    always #(CLK_PERIOD / 2) clk = ~clk;

    msx_io_devices i_msx_io_devices (
        .clk(clk), .reset(reset), .io_req_in(io_req_in), .req(req),
        .windows(windows), .kb_rows(kb_rows), .ack(ack), .rdata(rdata),
        .segments(segments), .slot_config(slot_config), .keybeep(keybeep),
        .reset_lock(reset_lock)
    );

    io_checker i_io_checker (
        .clk(clk), .reset(reset), .io_req_in(io_req_in), .req(req),
        .windows(windows), .kb_rows(kb_rows), .ack(ack), .rdata(rdata),
        .segments(segments), .slot_config(slot_config), .keybeep(keybeep),
        .reset_lock(reset_lock), .error_count(error_count), .access_count(access_count)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic randomize_keyboard();
        logic [31:0] r;
        for (int i = 0; i < `MSX_KB_ROWS; i++) begin
            r = next_random();
            kb_rows[i] = r[31:24];
        end
    endtask

    // Mostly the mapped ranges, sometimes any port
    function automatic msx_bus_pkg::io_port_t pick_port();
        logic [31:0] r;
        r = next_random();
        if ((r[31:16] % 16'd10) < 16'd7) begin
            case (r[13:12])
                2'd0, 2'd1: return 8'hFC | {6'b0, r[11:10]};
                2'd2:       return 8'hA8 | {6'b0, r[11:10]};
                default:    return 8'hF4;
            endcase
        end
        return r[23:16];
    endfunction

    task automatic run_access(input msx_bus_pkg::io_port_t port, input logic write,
                              input msx_bus_pkg::io_byte_t wdata, input int hold);
        int waited;
        @(posedge clk);
        #2;
        io_req_in.port  = port;
        io_req_in.write = write;
        io_req_in.wdata = wdata;
        req = 1'b1;
        issued++;
        waited = 0;
        while (ack !== 1'b1 && waited < ACK_TIMEOUT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (ack !== 1'b1) begin
            $display("TIMEOUT %0t: ack did not rise for port %02h", $time, port);
            timeouts++;
            aborted = 1'b1;
        end
        // Extra cycles with req held keep ack high
        for (int i = 0; i < hold; i++) begin
            @(posedge clk);
            #2;
        end
        req = 1'b0;
        waited = 0;
        while (ack !== 1'b0 && waited < ACK_TIMEOUT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (ack !== 1'b0) begin
            $display("TIMEOUT %0t: ack did not fall for port %02h", $time, port);
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    initial begin
        logic [31:0]           r;
        msx_bus_pkg::io_port_t port;
        reset     = 1'b1;
        req       = 1'b0;
        io_req_in = '0;
        // Mapper FC-FF, PPI A8-AB, reset status F4
        windows[0] = '{enable: 1'b1, base: 8'hFC, mask: 8'hFC};
        windows[1] = '{enable: 1'b1, base: 8'hA8, mask: 8'hFC};
        windows[2] = '{enable: 1'b1, base: 8'hF4, mask: 8'hFF};
        randomize_keyboard();
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;

        // Reset values of the four mapper pages
        for (int p = 0; p < 4 && !aborted; p++) begin
            run_access(8'hFC + 8'(p), 1'b0, 8'h00, 0);
        end

        for (int n = 0; n < NUM_ACCESSES && !aborted; n++) begin
            if (n == NUM_ACCESSES / 2) windows[1].enable = 1'b0;
            if (n == NUM_ACCESSES / 2 + 60) windows[1].enable = 1'b1;
            if (n % 16 == 0) randomize_keyboard();
            r    = next_random();
            port = pick_port();
            run_access(port, r[20], r[31:24], int'(r[15:12]) % 6);
        end

        repeat (4) @(posedge clk);
        if (access_count != issued) begin
            $display("Checker saw %0d accesses but %0d were issued", access_count, issued);
        end
        $display("Accesses %0d of %0d, errors %0d, timeouts %0d",
                 access_count, issued, error_count, timeouts);
        if (error_count == 0 && timeouts == 0 && access_count == issued) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+src
src/msx_bus_pkg.sv
src/msx_dev_pkg.sv
src/io_port_decode.sv
src/dev_mapper_regs.sv
src/dev_ppi.sv
src/dev_reset_status.sv
src/io_result_merge.sv
src/msx_io_devices.sv
verification/io_checker.sv
verification/tb_msx_io.sv

//--- run_sim.sh
#!/bin/bash
# Build the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps -f project.f \
    --top-module tb_msx_io -o sim_msx_io \
    && ./obj_dir/sim_msx_io | tee sim.log \
    || { echo "Build or simulation did not complete"; exit 1; }

# The run passes only when the log holds the pass line
grep -qx "No errors" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
